/* src/lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// Data word width in bits
`define LC3B_WORD_W 16

// One memory line is eight words
`define LC3B_LINE_W 128

// Depth of the data memory in lines
`define LC3B_MEM_LINES 64

// trapvect8 is a word index, so it becomes a byte address
`define LC3B_TRAP_SHIFT 1

`endif

/* src/lc3b_pkg.sv */
`include "lc3b_defines.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

    // Ordered n, z, p from msb to lsb
    typedef logic [2:0] lc3b_cc;

    typedef logic [`LC3B_LINE_W-1:0] lc3b_line;

    // One enable bit per byte of a line
    typedef logic [`LC3B_LINE_W/8-1:0] lc3b_sel;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        cc_src_pcn = 2'b00,
        cc_src_alu = 2'b01,
        cc_src_mdr = 2'b10,
        cc_src_sr2 = 2'b11
    } lc3b_cc_src;

    typedef enum logic [1:0] {
        addr_src_trap = 2'b00,
        addr_src_alu  = 2'b01,
        addr_src_mdr  = 2'b10
    } lc3b_addr_src;

    typedef enum logic {
        st_first    = 1'b0,
        st_indirect = 1'b1
    } lc3b_mem_state;

endpackage

/* src/cc_unit.sv */
`timescale 1ns/1ns

`include "lc3b_defines.svh"

module cc_unit
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  lc3b_cc_src cc_src,
    input  logic       cc_load,
    input  logic       br_en_load,
    input  lc3b_word   pcn_in,
    input  lc3b_word   alu_in,
    input  lc3b_word   mdr_in,
    input  lc3b_word   sr2_in,
    input  lc3b_cc     nzp,
    output logic       br_en
);

    lc3b_word cc_word;
    lc3b_cc   cc_next;
    lc3b_cc   cc_reg;

    // Source word for the new condition code
    always_comb begin
        unique case (cc_src)
            cc_src_pcn: cc_word = pcn_in;
            cc_src_alu: cc_word = alu_in;
            cc_src_mdr: cc_word = mdr_in;
            cc_src_sr2: cc_word = sr2_in;
        endcase
    end

    // Sign bit wins over the zero test
    always_comb begin
        if (cc_word[`LC3B_WORD_W-1]) begin
            cc_next = 3'b100;
        end else if (cc_word == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_reg <= 3'b010;
        end else if (cc_load && !stall) begin
            cc_reg <= cc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            br_en <= 1'b0;
        end else if (br_en_load && !stall) begin
            br_en <= |(cc_reg & nzp);
        end
    end

    // Exactly one of n, z, p is ever set
    a_cc_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(cc_reg));

endmodule

/* src/mem_access_ctrl.sv */
`timescale 1ns/1ns

module mem_access_ctrl
    import lc3b_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  lc3b_opcode   opcode,
    input  logic         data_memory_access,
    input  logic         ack,
    output lc3b_addr_src addr_src,
    output logic         we,
    output logic         mdr_load,
    output logic         request_stall
);

    lc3b_mem_state state;
    lc3b_mem_state state_next;
    logic          is_indirect;
    logic          is_store;
    logic          final_phase;

    assign is_indirect = (opcode == op_ldi) || (opcode == op_sti);
    assign is_store    = (opcode == op_str) || (opcode == op_stb);

    // Single accesses finish on their only ack
    assign final_phase = !is_indirect || (state == st_indirect);

    always_comb begin
        if (opcode == op_trap) begin
            addr_src = addr_src_trap;
        end else if (is_indirect && (state == st_indirect)) begin
            addr_src = addr_src_mdr;
        end else begin
            addr_src = addr_src_alu;
        end
    end

    // STI writes only once the pointer is known
    always_comb begin
        we = 1'b0;
        if (data_memory_access) begin
            if (is_store) begin
                we = 1'b1;
            end else if ((opcode == op_sti) && (state == st_indirect)) begin
                we = 1'b1;
            end
        end
    end

    assign mdr_load      = data_memory_access && ack && is_indirect && (state == st_first);
    assign request_stall = data_memory_access && !(ack && final_phase);

    always_comb begin
        state_next = state;
        if (!data_memory_access) begin
            state_next = st_first;
        end else if (ack) begin
            if ((state == st_first) && is_indirect) begin
                state_next = st_indirect;
            end else begin
                state_next = st_first;
            end
        end
    end

    // Advances even under stall since the pipeline waits on request_stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_first;
        end else begin
            state <= state_next;
        end
    end

    a_we_in_access: assert property (
        @(posedge clk) disable iff (!rst_n) we |-> data_memory_access
    );

    a_indirect_in_access: assert property (
        @(posedge clk) disable iff (!rst_n) (state == st_indirect) |-> data_memory_access
    );

endmodule

/* src/lane_steer.sv */
`timescale 1ns/1ns

module lane_steer
    import lc3b_pkg::*;
(
    input  logic       word_align,
    input  logic [3:0] addr_low,
    input  lc3b_word   sr2_in,
    input  lc3b_line   dat_s,
    output lc3b_sel    sel,
    output lc3b_line   dat_m,
    output lc3b_word   mdr_out
);

    logic [2:0] slot;

    // Word slot within the line
    assign slot = addr_low[3:1];

    // Byte enables
    always_comb begin
        sel = '0;
        if (word_align) begin
            sel[slot*2 +: 2] = 2'b11;
        end else if (addr_low[0]) begin
            sel[slot*2 +: 2] = 2'b10;
        end else begin
            sel[slot*2 +: 2] = 2'b01;
        end
    end

    // Store data placed in its lane
    always_comb begin
        dat_m = '0;
        if (word_align) begin
            dat_m[slot*16 +: 16] = sr2_in;
        end else if (addr_low[0]) begin
            dat_m[slot*16 +: 16] = {sr2_in[7:0], 8'h00};
        end else begin
            dat_m[slot*16 +: 16] = {8'h00, sr2_in[7:0]};
        end
    end

    // Byte loads come back zero extended
    always_comb begin
        mdr_out = '0;
        if (word_align) begin
            mdr_out = dat_s[slot*16 +: 16];
        end else begin
            mdr_out[7:0] = dat_s[addr_low*8 +: 8];
        end
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/1ns

`include "lc3b_defines.svh"

module mem_stage
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  lc3b_opcode opcode,
    input  lc3b_cc_src cc_src,
    input  logic       cc_load,
    input  logic       br_en_load,
    input  logic       data_memory_access,
    input  logic       word_align,
    input  lc3b_word   alu_in,
    input  lc3b_word   ir_in,
    input  lc3b_word   pcn_in,
    input  lc3b_word   sr2_in,
    output logic       br_en,
    output lc3b_word   mdr_out,
    output logic       request_stall,
    output logic       cyc,
    output logic       stb,
    output logic       we,
    output logic [11:0] adr,
    output lc3b_sel    sel,
    output lc3b_line   dat_m,
    input  logic       ack,
    input  lc3b_line   dat_s
);

    lc3b_addr_src addr_src;
    logic         mdr_load;
    lc3b_word     internal_mdr;
    lc3b_word     trap_vect;
    lc3b_word     data_addr;

    assign trap_vect = lc3b_word'(ir_in[7:0]) << `LC3B_TRAP_SHIFT;

    always_comb begin
        case (addr_src)
            addr_src_trap: data_addr = trap_vect;
            addr_src_mdr:  data_addr = internal_mdr;
            default:       data_addr = alu_in;
        endcase
    end

    // Line address from bits 15 to 4 while the low nibble picks the lane
    assign adr = data_addr[15:4];
    assign cyc = data_memory_access;
    assign stb = data_memory_access;

    // Holds the pointer between the two phases of LDI and STI
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            internal_mdr <= '0;
        end else if (mdr_load && !stall) begin
            internal_mdr <= mdr_out;
        end
    end

    cc_unit u_cc_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .cc_src     (cc_src),
        .cc_load    (cc_load),
        .br_en_load (br_en_load),
        .pcn_in     (pcn_in),
        .alu_in     (alu_in),
        .mdr_in     (mdr_out),
        .sr2_in     (sr2_in),
        .nzp        (ir_in[11:9]),
        .br_en      (br_en)
    );

    mem_access_ctrl u_mem_access_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .opcode             (opcode),
        .data_memory_access (data_memory_access),
        .ack                (ack),
        .addr_src           (addr_src),
        .we                 (we),
        .mdr_load           (mdr_load),
        .request_stall      (request_stall)
    );

    lane_steer u_lane_steer (
        .word_align (word_align),
        .addr_low   (data_addr[3:0]),
        .sr2_in     (sr2_in),
        .dat_s      (dat_s),
        .sel        (sel),
        .dat_m      (dat_m),
        .mdr_out    (mdr_out)
    );

endmodule

/* src/line_memory.sv */
`timescale 1ns/1ns

`include "lc3b_defines.svh"

module line_memory
    import lc3b_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [11:0] adr,
    input  lc3b_sel     sel,
    input  lc3b_line    dat_m,
    output logic        ack,
    output lc3b_line    dat_s
);

    localparam int IDX_W = $clog2(`LC3B_MEM_LINES);

    lc3b_line             mem [`LC3B_MEM_LINES];
    logic [IDX_W-1:0]     idx;
    logic                 wr_en;

    // Upper line address bits are ignored
    assign idx = adr[IDX_W-1:0];

    assign dat_s = mem[idx];

    // Commit on the acknowledged cycle
    assign wr_en = cyc && stb && we && ack;

    // Pulses one cycle after each unacknowledged strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc && stb && !ack;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_MEM_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < `LC3B_LINE_W/8; b++) begin
                if (sel[b]) begin
                    mem[idx][b*8 +: 8] <= dat_m[b*8 +: 8];
                end
            end
        end
    end

    a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) ack |-> stb);

endmodule

/* src/mem_subsystem_top.sv */
`timescale 1ns/1ns

module mem_subsystem_top
    import lc3b_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  lc3b_opcode opcode,
    input  lc3b_cc_src cc_src,
    input  logic       cc_load,
    input  logic       br_en_load,
    input  logic       data_memory_access,
    input  logic       word_align,
    input  lc3b_word   alu_in,
    input  lc3b_word   ir_in,
    input  lc3b_word   pcn_in,
    input  lc3b_word   sr2_in,
    output logic       br_en,
    output lc3b_word   mdr_out,
    output logic       request_stall
);

    // Data bus between the stage and the memory
    logic        cyc;
    logic        stb;
    logic        we;
    logic [11:0] adr;
    lc3b_sel     sel;
    lc3b_line    dat_m;
    logic        ack;
    lc3b_line    dat_s;

    mem_stage u_mem_stage (
        .clk                (clk),
        .rst_n              (rst_n),
        .stall              (stall),
        .opcode             (opcode),
        .cc_src             (cc_src),
        .cc_load            (cc_load),
        .br_en_load         (br_en_load),
        .data_memory_access (data_memory_access),
        .word_align         (word_align),
        .alu_in             (alu_in),
        .ir_in              (ir_in),
        .pcn_in             (pcn_in),
        .sr2_in             (sr2_in),
        .br_en              (br_en),
        .mdr_out            (mdr_out),
        .request_stall      (request_stall),
        .cyc                (cyc),
        .stb                (stb),
        .we                 (we),
        .adr                (adr),
        .sel                (sel),
        .dat_m              (dat_m),
        .ack                (ack),
        .dat_s              (dat_s)
    );

    line_memory u_line_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .sel   (sel),
        .dat_m (dat_m),
        .ack   (ack),
        .dat_s (dat_s)
    );

endmodule

/* testbench/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// The columns are name, opcode, word_align, address mode (0 fixed, 1 new random, 2 last random),
// alu, sr2 random, sr2, pcn, cc source, cc_load, br_en_load, stall, ir, expected br_en
task automatic load_vectors();
    // Word store and load
    add_vec("str_word", op_str, 1, 0, 'h24, 1, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_word", op_ldr, 1, 0, 'h24, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("str_rand", op_str, 1, 1, 'h0, 1, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_rand", op_ldr, 1, 2, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    // Byte lanes inside one word
    add_vec("str_fill", op_str, 1, 0, 'h52, 0, 'hbeef, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("stb_even", op_stb, 0, 0, 'h52, 0, 'h12a5, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_half", op_ldr, 1, 0, 'h52, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("stb_odd", op_stb, 0, 0, 'h53, 0, 'h345c, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldb_even", op_ldb, 0, 0, 'h52, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldb_odd", op_ldb, 0, 0, 'h53, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_bytes", op_ldr, 1, 0, 'h52, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_neighbor", op_ldr, 1, 0, 'h50, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    // Indirect accesses through a pointer at 0x0100
    add_vec("str_ptr", op_str, 1, 0, 'h100, 0, 'h230, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("str_target", op_str, 1, 0, 'h230, 1, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldi", op_ldi, 1, 0, 'h100, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("sti", op_sti, 1, 0, 'h100, 1, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_target", op_ldr, 1, 0, 'h230, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("ldr_ptr", op_ldr, 1, 0, 'h100, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    // Vector 0x23 lives at byte address 0x46
    add_vec("str_vect", op_str, 1, 0, 'h46, 1, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'h0, 0);
    add_vec("trap", op_trap, 1, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 0, 0, 'hf023, 0);
    // Condition codes and branch enable
    add_vec("cc_neg", op_br, 0, 0, 'h8001, 0, 'h0, 'h5, cc_src_alu, 1, 0, 0, 'h0, 0);
    add_vec("br_n_hit", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'h800, 1);
    add_vec("br_n_miss", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'h600, 0);
    add_vec("cc_zero", op_br, 0, 0, 'h7, 0, 'h0, 'h9000, cc_src_sr2, 1, 0, 0, 'h0, 0);
    add_vec("br_z_hit", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'h400, 1);
    add_vec("br_z_miss", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'ha00, 0);
    add_vec("cc_pos", op_br, 0, 0, 'h0, 0, 'hffff, 'h3000, cc_src_pcn, 1, 0, 0, 'h0, 0);
    add_vec("br_p_hit", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'h200, 1);
    add_vec("br_p_miss", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'hc00, 0);
    // Stall holds both registers
    add_vec("stall_cc", op_br, 0, 0, 'h8000, 0, 'h0, 'h0, cc_src_alu, 1, 0, 1, 'h0, 0);
    add_vec("stall_br", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 1, 'h200, 0);
    add_vec("release_br", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'h200, 1);
    add_vec("release_cc", op_br, 0, 0, 'h8000, 0, 'h0, 'h0, cc_src_alu, 1, 0, 0, 'h0, 1);
    add_vec("release_br_n", op_br, 0, 0, 'h0, 0, 'h0, 'h0, cc_src_alu, 0, 1, 0, 'h200, 0);
endtask

`endif

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ns

module tb_mem_subsystem
    import lc3b_pkg::*;
;

    logic       clk;
    logic       rst_n;
    logic       stall;
    lc3b_opcode opcode;
    lc3b_cc_src cc_src;
    logic       cc_load;
    logic       br_en_load;
    logic       data_memory_access;
    logic       word_align;
    lc3b_word   alu_in;
    lc3b_word   ir_in;
    lc3b_word   pcn_in;
    lc3b_word   sr2_in;
    logic       br_en;
    lc3b_word   mdr_out;
    logic       request_stall;

    // Vector table columns
    string       v_name[$];
    lc3b_opcode  v_op[$];
    logic        v_wa[$];
    int          v_amode[$];
    logic [15:0] v_alu[$];
    logic        v_srand[$];
    logic [15:0] v_sr2[$];
    logic [15:0] v_pcn[$];
    lc3b_cc_src  v_src[$];
    logic        v_ccl[$];
    logic        v_brl[$];
    logic        v_stall[$];
    logic [15:0] v_ir[$];
    logic        v_br[$];

    // Byte image of the data memory with little endian words
    logic [7:0]  mirror [1024];
    logic [15:0] lfsr;
    logic [15:0] last_addr;

    mem_subsystem_top u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .stall              (stall),
        .opcode             (opcode),
        .cc_src             (cc_src),
        .cc_load            (cc_load),
        .br_en_load         (br_en_load),
        .data_memory_access (data_memory_access),
        .word_align         (word_align),
        .alu_in             (alu_in),
        .ir_in              (ir_in),
        .pcn_in             (pcn_in),
        .sr2_in             (sr2_in),
        .br_en              (br_en),
        .mdr_out            (mdr_out),
        .request_stall      (request_stall)
    );

    always #4 clk = ~clk;

    task automatic add_vec(input string name, input lc3b_opcode op, input logic wa,
                           input int amode, input logic [15:0] alu, input logic srand,
                           input logic [15:0] sr2, input logic [15:0] pcn,
                           input lc3b_cc_src src, input logic ccl, input logic brl,
                           input logic stl, input logic [15:0] ir, input logic br);
        v_name.push_back(name);
        v_op.push_back(op);
        v_wa.push_back(wa);
        v_amode.push_back(amode);
        v_alu.push_back(alu);
        v_srand.push_back(srand);
        v_sr2.push_back(sr2);
        v_pcn.push_back(pcn);
        v_src.push_back(src);
        v_ccl.push_back(ccl);
        v_brl.push_back(brl);
        v_stall.push_back(stl);
        v_ir.push_back(ir);
        v_br.push_back(br);
    endtask

    `include "tb_vectors.svh"

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [15:0] read_word(input logic [15:0] a);
        return {mirror[{a[9:1], 1'b1}], mirror[{a[9:1], 1'b0}]};
    endfunction

    task automatic write_word(input logic [15:0] a, input logic [15:0] d);
        mirror[{a[9:1], 1'b1}] = d[15:8];
        mirror[{a[9:1], 1'b0}] = d[7:0];
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Counts stalled cycles sampled mid cycle
    task automatic wait_release(output int cycles);
        logic released;
        released = 1'b0;
        cycles = 0;
        while (!released && cycles < 20) begin
            @(negedge clk);
            if (request_stall) begin
                cycles++;
            end else begin
                released = 1'b1;
            end
        end
        if (!released) begin
            $display("request_stall never released");
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input int k);
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] exp_mdr;
        logic        access;
        logic        is_load;
        int          cycles;
        int          exp_cycles;
        addr = v_alu[k];
        if (v_amode[k] == 1) begin
            take_bits(10, addr);
            if (v_wa[k]) begin
                addr[0] = 1'b0;
            end
            last_addr = addr;
        end else if (v_amode[k] == 2) begin
            addr = last_addr;
        end
        data = v_sr2[k];
        if (v_srand[k]) begin
            take_bits(16, data);
        end
        is_load = v_op[k] inside {op_ldr, op_ldb, op_ldi, op_trap};
        access  = is_load || (v_op[k] inside {op_str, op_stb, op_sti});
        exp_cycles = (v_op[k] inside {op_ldi, op_sti}) ? 3 : 1;
        case (v_op[k])
            op_ldr:  exp_mdr = read_word(addr);
            op_ldb:  exp_mdr = {8'h00, mirror[addr[9:0]]};
            op_ldi:  exp_mdr = read_word(read_word(addr));
            op_trap: exp_mdr = read_word({7'b0, v_ir[k][7:0], 1'b0});
            default: exp_mdr = '0;
        endcase

        @(posedge clk);
        #1;
        opcode             = v_op[k];
        word_align         = v_wa[k];
        alu_in             = addr;
        sr2_in             = data;
        pcn_in             = v_pcn[k];
        cc_src             = v_src[k];
        cc_load            = v_ccl[k];
        br_en_load         = v_brl[k];
        stall              = v_stall[k];
        ir_in              = v_ir[k];
        data_memory_access = access;

        if (access) begin
            wait_release(cycles);
            if (is_load) begin
                check({v_name[k], " mdr_out"}, exp_mdr, mdr_out);
            end
            check({v_name[k], " stall cycles"}, exp_cycles, cycles);
            case (v_op[k])
                op_str:  write_word(addr, data);
                op_stb:  mirror[addr[9:0]] = data[7:0];
                op_sti:  write_word(read_word(addr), data);
                default: ;
            endcase
        end else begin
            @(negedge clk);
            check({v_name[k], " request_stall"}, 0, request_stall);
        end

        @(posedge clk);
        #1;
        data_memory_access = 1'b0;
        cc_load            = 1'b0;
        br_en_load         = 1'b0;
        stall              = 1'b0;
        @(negedge clk);
        check({v_name[k], " br_en"}, v_br[k], br_en);
    endtask

    initial begin
        clk                = 1'b0;
        rst_n              = 1'b0;
        stall              = 1'b0;
        opcode             = op_br;
        cc_src             = cc_src_alu;
        cc_load            = 1'b0;
        br_en_load         = 1'b0;
        data_memory_access = 1'b0;
        word_align         = 1'b1;
        alu_in             = '0;
        ir_in              = '0;
        pcn_in             = '0;
        sr2_in             = '0;
        lfsr               = 16'd39;
        last_addr          = '0;
        for (int i = 0; i < 1024; i++) begin
            mirror[i] = 8'h00;
        end
        load_vectors();

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check("reset request_stall", 0, request_stall);
        check("reset br_en", 0, br_en);

        for (int k = 0; k < v_name.size(); k++) begin
            apply_row(k);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* all.f */
+incdir+src
+incdir+testbench
src/lc3b_pkg.sv
src/cc_unit.sv
src/mem_access_ctrl.sv
src/lane_steer.sv
src/mem_stage.sv
src/line_memory.sv
src/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv
